//--- tnn_classifier.f
+incdir+tb
rtl/tnn_pkg.sv
rtl/tnn_hidden_layer.sv
rtl/tnn_output_layer.sv
rtl/tnn_argmax.sv
rtl/tnn_classifier.sv
tb/tb_tnn_classifier.sv

//--- Makefile
# Verilator build and run for the ternary network classifier

SIM      ?= verilator
TOP      ?= tb_tnn_classifier
FILELIST ?= tnn_classifier.f
BUILD    ?= obj_dir
VFLAGS   ?= --binary --timing --assert -Wno-fatal
EXTRA    ?=

SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard tb/*.svh)
SIM_BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD)

//--- tb/tnn_ref_model.svh
`ifndef TNN_REF_MODEL_SVH
`define TNN_REF_MODEL_SVH

localparam int VEC_BITS = tnn_pkg::FEAT_CNT * tnn_pkg::FEAT_BITS;

// Weight is +1, 0 or -1 from the two sign tables
function automatic int model_weight(input int n, input int f);
    return int'(tnn_pkg::HIDDEN_POS[n][f]) - int'(tnn_pkg::HIDDEN_NEG[n][f]);
endfunction

function automatic tnn_pkg::hidden_t model_hidden(input logic [VEC_BITS-1:0] feats);
    tnn_pkg::hidden_t h;
    int               sum;
    h = '0;
    for (int n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin
        sum = 0;
        for (int f = 0; f < tnn_pkg::FEAT_CNT; f++) begin
            sum += model_weight(n, f) * int'(feats[f*tnn_pkg::FEAT_BITS +: tnn_pkg::FEAT_BITS]);
        end
        h[n] = (sum >= 0);                       // Neuron fires on zero too
    end
    return h;
endfunction

// Twice the agreeing used neurons, plus the class bias
function automatic int model_score(input tnn_pkg::hidden_t h, input int c);
    int count;
    count = 0;
    for (int j = 0; j < tnn_pkg::HIDDEN_CNT; j++) begin
        if (tnn_pkg::CLASS_USE[c][j] && (h[j] == tnn_pkg::CLASS_POL[c][j])) begin
            count++;
        end
    end
    return 2 * count + int'(tnn_pkg::CLASS_BIAS[c]);
endfunction

function automatic int model_predict(input logic [VEC_BITS-1:0] feats);
    tnn_pkg::hidden_t h;
    int               best;
    int               idx;
    h    = model_hidden(feats);
    best = model_score(h, 0);
    idx  = 0;
    for (int c = 1; c < tnn_pkg::CLASS_CNT; c++) begin
        if (model_score(h, c) > best) begin
            best = model_score(h, c);
            idx  = c;
        end
    end
    return idx;
endfunction

function automatic int model_max_score(input logic [VEC_BITS-1:0] feats);
    tnn_pkg::hidden_t h;
    int               best;
    h    = model_hidden(feats);
    best = model_score(h, 0);
    for (int c = 1; c < tnn_pkg::CLASS_CNT; c++) begin
        if (model_score(h, c) > best) begin
            best = model_score(h, c);
        end
    end
    return best;
endfunction

// Number of classes that share the top score
function automatic int model_max_count(input logic [VEC_BITS-1:0] feats);
    tnn_pkg::hidden_t h;
    int               best;
    int               cnt;
    h    = model_hidden(feats);
    best = model_max_score(feats);
    cnt  = 0;
    for (int c = 0; c < tnn_pkg::CLASS_CNT; c++) begin
        if (model_score(h, c) == best) begin
            cnt++;
        end
    end
    return cnt;
endfunction

function automatic int model_lowest_max(input logic [VEC_BITS-1:0] feats);
    tnn_pkg::hidden_t h;
    int               best;
    int               idx;
    h    = model_hidden(feats);
    best = model_max_score(feats);
    idx  = 0;
    for (int c = tnn_pkg::CLASS_CNT - 1; c >= 0; c--) begin
        if (model_score(h, c) == best) begin
            idx = c;                             // Last hit is the lowest index
        end
    end
    return idx;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

//--- tb/tb_tnn_classifier.sv
`timescale 1ns/1ps

module tb_tnn_classifier;

    `include "tnn_ref_model.svh"

    localparam int RESET_CYCLES     = 10;
    localparam int LATENCY          = 2;
    localparam int DRAIN_LIMIT      = 20;
    localparam int RESULT_LIMIT     = 10;
    localparam int TIE_SEARCH_LIMIT = 5000;
    localparam int RUN_LIMIT_NS     = 200000;

    logic                                clk;
    logic                                rst_n;
    logic [VEC_BITS-1:0]                 features;
    logic                                features_valid;
    logic [tnn_pkg::CLASS_BITS-1:0]      prediction;
    logic                                prediction_valid;

    logic [31:0] rng_state;
    int          cycle = 0;
    int          sent = 0;
    int          checked = 0;
    int          exp_pred[$];
    int          exp_due[$];                     // Cycle count at which the pulse is due

    tnn_classifier dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .features         (features),
        .features_valid   (features_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [VEC_BITS-1:0] random_vector();
        logic [VEC_BITS-1:0] vec;
        vec[31:0]  = next_rand();
        vec[63:32] = next_rand();
        return vec;
    endfunction

    // Compares every output pulse with the oldest pending expectation
    always @(negedge clk) begin : result_monitor
        int due;
        int want;
        if (rst_n) begin
            if (prediction_valid) begin
                assert (exp_pred.size() > 0)
                    else stop_with_failure($sformatf(
                        "error at %0t: prediction_valid pulse with no vector pending", $time));
                if (exp_pred.size() > 0) begin
                    due  = exp_due.pop_front();
                    want = exp_pred.pop_front();
                    checked++;
                    assert (cycle == due)
                        else stop_with_failure($sformatf(
                            "error at %0t: result arrived at cycle %0d, due at cycle %0d",
                            $time, cycle, due));
                    assert (int'(prediction) == want)
                        else stop_with_failure($sformatf(
                            "error at %0t: prediction %0d, expected %0d",
                            $time, prediction, want));
                end
            end else if (exp_due.size() > 0) begin
                assert (exp_due[0] > cycle)
                    else stop_with_failure($sformatf(
                        "error at %0t: missing prediction_valid pulse due at cycle %0d",
                        $time, exp_due[0]));
            end
        end
    end

    task automatic send_vector(input logic [VEC_BITS-1:0] vec, input int want);
        @(negedge clk);
        features       = vec;
        features_valid = 1'b1;
        exp_pred.push_back(want);
        exp_due.push_back(cycle + LATENCY);
        sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            features_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pred.size() > 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            features_valid = 1'b0;
            waited++;
        end
        if (exp_pred.size() > 0) begin
            stop_with_failure($sformatf(
                "timeout: %0d results still pending after %0d cycles", exp_pred.size(), waited));
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!prediction_valid)
                else stop_with_failure($sformatf(
                    "error at %0t: prediction_valid high during reset", $time));
        end
        rst_n = 1'b1;
    endtask

    task automatic test_reset_quiet();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!prediction_valid)
                else stop_with_failure($sformatf(
                    "error at %0t: prediction_valid high with no input strobe", $time));
        end
    endtask

    // All sums are zero, so every neuron fires
    task automatic test_zero_vector();
        int lat;
        bit seen;
        send_vector('0, model_predict('0));
        lat  = 0;
        seen = 1'b0;
        while (!seen && lat < RESULT_LIMIT) begin
            @(negedge clk);
            features_valid = 1'b0;
            lat++;
            if (lat == 1) begin
                assert (dut.hidden == '1)
                    else stop_with_failure($sformatf(
                        "error at %0t: hidden activations %h, expected all ones",
                        $time, dut.hidden));
            end
            seen = prediction_valid;
        end
        if (!seen) begin
            stop_with_failure("timeout: no prediction_valid pulse for the zero vector");
        end else begin
            assert (lat == LATENCY)
                else stop_with_failure($sformatf(
                    "error at %0t: latency %0d cycles, expected %0d", $time, lat, LATENCY));
        end
        wait_drain();
    endtask

    task automatic test_corner_vectors();
        logic [VEC_BITS-1:0] vec;
        vec = '1;
        send_vector(vec, model_predict(vec));
        for (int f = 0; f < tnn_pkg::FEAT_CNT; f++) begin
            vec = '0;
            vec[f*tnn_pkg::FEAT_BITS +: tnn_pkg::FEAT_BITS] = 4'hf;
            send_vector(vec, model_predict(vec));
        end
        wait_drain();
    endtask

    task automatic test_tie();
        logic [VEC_BITS-1:0] vec;
        int                  tries;
        bit                  found;
        vec   = '0;
        tries = 0;
        found = 1'b0;
        while (!found && tries < TIE_SEARCH_LIMIT) begin
            vec   = random_vector();
            found = (model_max_count(vec) > 1);
            tries++;
        end
        if (!found) begin
            stop_with_failure("no vector with tied top class scores was found by the search");
        end else begin
            send_vector(vec, model_lowest_max(vec));
            wait_drain();
        end
    endtask

    task automatic test_back_to_back();
        logic [VEC_BITS-1:0] vec;
        for (int i = 0; i < 300; i++) begin
            vec = random_vector();
            send_vector(vec, model_predict(vec));
        end
        wait_drain();
    endtask

    // Idle gaps of one to four cycles between random vectors
    task automatic test_random_gaps();
        logic [VEC_BITS-1:0] vec;
        logic [31:0]         r;
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            if (r[1:0] == 2'd0) begin
                idle_cycles(int'(r[3:2]) + 1);
            end else begin
                vec = random_vector();
                send_vector(vec, model_predict(vec));
            end
        end
        wait_drain();
    endtask

    initial begin
        #(RUN_LIMIT_NS);
        stop_with_failure("timeout: simulation did not finish within the time limit");
    end

    initial begin
        rng_state      = 32'hdee47a92;
        rst_n          = 1'b0;
        features       = '0;
        features_valid = 1'b0;
        apply_reset();
        test_reset_quiet();
        test_zero_vector();
        test_corner_vectors();
        test_tie();
        test_back_to_back();
        test_random_gaps();
        idle_cycles(4);
        if (exp_pred.size() == 0 && checked == sent) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("error at %0t: %0d results checked for %0d vectors sent",
                $time, checked, sent));
        end
    end

endmodule

//--- rtl/tnn_classifier.sv
`timescale 1ns/1ps

module tnn_classifier (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  tnn_pkg::feature_t [tnn_pkg::FEAT_CNT-1:0]    features,
    input  logic                                         features_valid,
    output logic [tnn_pkg::CLASS_BITS-1:0]               prediction,
    output logic                                         prediction_valid
);

    tnn_pkg::hidden_t                            hidden;
    logic                                        hidden_valid;
    tnn_pkg::score_t [tnn_pkg::CLASS_CNT-1:0]    scores;

    tnn_hidden_layer u_hidden (
        .clk            (clk),
        .rst_n          (rst_n),
        .features       (features),
        .features_valid (features_valid),
        .hidden         (hidden),
        .hidden_valid   (hidden_valid)
    );

    // Scores are combinational off the stage 1 register
    tnn_output_layer u_output (
        .hidden (hidden),
        .scores (scores)
    );

    tnn_argmax #(
        .class_cnt  (tnn_pkg::CLASS_CNT),
        .score_bits (tnn_pkg::SCORE_BITS)
    ) u_argmax (
        .clk              (clk),
        .rst_n            (rst_n),
        .scores           (scores),
        .scores_valid     (hidden_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

endmodule

//--- rtl/tnn_argmax.sv
`timescale 1ns/1ps

module tnn_argmax #(
    parameter int class_cnt  = 10,
    parameter int score_bits = 7
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [class_cnt-1:0][score_bits-1:0]   scores,
    input  logic                                   scores_valid,
    output logic [tnn_pkg::CLASS_BITS-1:0]         prediction,
    output logic                                   prediction_valid
);

    logic [score_bits-1:0]          best_score;
    logic [tnn_pkg::CLASS_BITS-1:0] best_idx;

    // Strictly greater replaces, so the lowest index keeps a tie
    always_comb begin
        best_score = scores[0];
        best_idx   = '0;
        for (int c = 1; c < class_cnt; c++) begin
            if (scores[c] > best_score) begin
                best_score = scores[c];
                best_idx   = c[tnn_pkg::CLASS_BITS-1:0];
            end
        end
    end

    // Stage 2 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prediction       <= '0;
            prediction_valid <= 1'b0;
        end else begin
            prediction_valid <= scores_valid;
            if (scores_valid) begin
                prediction <= best_idx;
            end
        end
    end

endmodule

//--- rtl/tnn_output_layer.sv
`timescale 1ns/1ps

module tnn_output_layer (
    input  tnn_pkg::hidden_t                              hidden,
    output tnn_pkg::score_t [tnn_pkg::CLASS_CNT-1:0]      scores
);

    for (genvar c = 0; c < tnn_pkg::CLASS_CNT; c++) begin : g_class
        tnn_pkg::hidden_t              agree;
        logic [tnn_pkg::SUM_BITS-1:0]  count;

        // Used neuron whose activation matches the stored polarity
        assign agree = tnn_pkg::CLASS_USE[c] & ~(hidden ^ tnn_pkg::CLASS_POL[c]);

        always_comb begin
            count = '0;
            for (int j = 0; j < tnn_pkg::HIDDEN_CNT; j++) begin
                count = count + {{(tnn_pkg::SUM_BITS-1){1'b0}}, agree[j]};
            end
        end

        assign scores[c] = {count, 1'b0} + tnn_pkg::CLASS_BIAS[c];   // 2*count + bias
    end

endmodule

//--- rtl/tnn_hidden_layer.sv
`timescale 1ns/1ps

module tnn_hidden_layer (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  tnn_pkg::feature_t [tnn_pkg::FEAT_CNT-1:0]    features,
    input  logic                                         features_valid,
    output tnn_pkg::hidden_t                             hidden,
    output logic                                         hidden_valid
);

    logic signed [tnn_pkg::ACC_BITS-1:0] feat_ext [tnn_pkg::FEAT_CNT];
    tnn_pkg::hidden_t                    fire;

    // Features are unsigned, widen with a zero sign bit
    for (genvar f = 0; f < tnn_pkg::FEAT_CNT; f++) begin : g_ext
        assign feat_ext[f] = $signed({1'b0, features[f]});
    end

    for (genvar n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin : g_neuron
        logic signed [tnn_pkg::ACC_BITS-1:0] acc;

        always_comb begin
            acc = '0;
            for (int f = 0; f < tnn_pkg::FEAT_CNT; f++) begin
                if (tnn_pkg::HIDDEN_POS[n][f]) begin
                    acc = acc + feat_ext[f];
                end else if (tnn_pkg::HIDDEN_NEG[n][f]) begin
                    acc = acc - feat_ext[f];
                end
            end
        end

        assign fire[n] = (acc >= 0);             // Zero sum still fires
    end

    // Stage 1 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hidden       <= '0;
            hidden_valid <= 1'b0;
        end else begin
            hidden_valid <= features_valid;
            if (features_valid) begin
                hidden <= fire;
            end
        end
    end

endmodule

//--- rtl/tnn_pkg.sv
package tnn_pkg;

    localparam int FEAT_CNT   = 16;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 10;
    localparam int CLASS_BITS = 4;
    localparam int ACC_BITS   = 9;               // Signed, covers +/-240
    localparam int SUM_BITS   = 6;
    localparam int SCORE_BITS = SUM_BITS + 1;

    typedef logic [FEAT_BITS-1:0]  feature_t;
    typedef logic [HIDDEN_CNT-1:0] hidden_t;
    typedef logic [SCORE_BITS-1:0] score_t;

    // Bit f of entry n set means feature f is added into neuron n
    localparam logic [FEAT_CNT-1:0] HIDDEN_POS [HIDDEN_CNT] = '{
        16'b0101_0000_0100_1001,                 // Neuron 0
        16'b1011_0010_0000_0011,
        16'b0001_0000_0101_1010,
        16'b1110_1111_1000_0101,
        16'b0000_0000_0001_1010,
        16'b1010_0000_0010_0110,
        16'b0001_0110_0000_0001,
        16'b1010_1100_0000_0110,
        16'b0100_1010_1100_0000,
        16'b0001_0000_0101_1000,
        16'b1111_1000_0001_0011,                 // Neuron 10
        16'b0100_0000_0000_1110,
        16'b0100_0001_0110_1000,
        16'b1010_0001_1000_0000,
        16'b1110_1000_1111_0100,
        16'b0100_1010_0000_0000,
        16'b1011_0000_0000_1101,
        16'b1100_0010_1011_1100,
        16'b0001_0000_0001_1010,
        16'b1010_0100_0001_1010,
        16'b1010_0000_0000_1010,                 // Neuron 20
        16'b0110_1101_1000_0010,
        16'b1000_1011_1101_0000,
        16'b0100_0001_0011_1000,
        16'b0000_0100_0000_0110,
        16'b1010_0000_0001_1010,
        16'b0100_1010_0101_0010,
        16'b1111_1011_0001_0000,
        16'b1010_1001_0000_1010,
        16'b0101_1010_0000_0011,
        16'b1011_0010_1010_0101,                 // Neuron 30
        16'b0100_1101_1100_0000,
        16'b1000_1010_1111_0100,
        16'b0100_1001_0010_0101,
        16'b1001_0010_1000_0001,
        16'b0001_0000_0000_0000,
        16'b1001_0010_0001_0001,
        16'b0110_0001_0000_1010,
        16'b0100_1000_0000_1010,
        16'b0100_1000_0010_1010
    };

    // Subtracted features, a bit clear in both tables is a zero weight
    localparam logic [FEAT_CNT-1:0] HIDDEN_NEG [HIDDEN_CNT] = '{
        16'b1010_1101_0010_0100,                 // Neuron 0
        16'b0100_0001_0100_0000,
        16'b1110_1010_0010_0101,
        16'b0001_0000_0101_1010,
        16'b1010_0000_1000_0101,
        16'b0100_1110_1100_0000,
        16'b1110_1001_0100_0000,
        16'b0101_0000_1000_1000,
        16'b1011_0000_0011_0001,
        16'b1110_1000_1010_0101,
        16'b0000_0011_1010_0100,                 // Neuron 10
        16'b1001_0111_0001_0000,
        16'b1011_1110_0000_0011,
        16'b0100_1000_0000_0000,
        16'b0000_0101_0000_1011,
        16'b1011_0000_1000_0001,
        16'b0100_1111_0101_0000,
        16'b0011_0101_0000_0010,
        16'b0010_1010_1000_0000,
        16'b0101_1010_1010_0001,
        16'b0101_1010_1000_0001,                 // Neuron 20
        16'b1001_0000_0001_1100,
        16'b0001_0000_0000_1011,
        16'b1011_1110_0000_0011,
        16'b1110_1010_0001_0000,
        16'b0101_1111_1000_0000,
        16'b0001_0101_1010_1101,
        16'b0000_0100_0000_1111,
        16'b0001_0010_0011_0101,
        16'b1010_0001_0101_1100,
        16'b0000_1001_0101_1010,                 // Neuron 30
        16'b1000_0010_0011_1010,
        16'b0010_0101_0000_0001,
        16'b1010_0000_0100_1010,
        16'b0100_1001_0000_0010,
        16'b1010_1001_1010_0100,
        16'b0010_0001_0000_0010,
        16'b1001_0000_1001_0001,
        16'b1011_0010_1011_0101,
        16'b1011_0001_1000_0001
    };

    // Hidden neurons that take part in each class vote
    localparam hidden_t CLASS_USE [CLASS_CNT] = '{
        40'b1000_0001_0010_1001_1100_1110_0101_1101_1011_1110,   // Class 0
        40'b0000_1011_0001_0100_1100_1110_1101_0111_1110_0011,
        40'b1000_0000_0101_0010_1001_1000_1111_1001_1111_1111,
        40'b0000_0000_1111_0000_1110_1000_1101_0111_0111_1111,
        40'b1000_1011_1111_1100_1111_1010_1110_1100_0010_1100,
        40'b1000_1000_1100_0101_0100_0010_1101_0110_1000_0111,
        40'b0010_0101_0000_1011_1111_1111_1101_1101_1110_0010,
        40'b0001_0000_1011_1011_1010_0000_0101_0000_1101_1101,
        40'b1010_1101_0111_1111_1010_0111_1110_1001_0101_0000,
        40'b0010_0001_1100_0010_1110_1011_1001_0000_1111_1000
    };

    // Activation level a used neuron must have to count for the class
    localparam hidden_t CLASS_POL [CLASS_CNT] = '{
        40'b0000_0000_0000_1000_0000_1000_0000_0100_1000_1010,   // Class 0
        40'b0000_0011_0000_0000_1000_0010_1101_0001_0000_0000,
        40'b1000_0000_0000_0010_1000_0000_1101_1001_0001_0101,
        40'b0000_0000_0000_0000_1100_1000_1001_0010_0101_0110,
        40'b1000_1010_1011_1000_0010_0000_1000_1100_0000_1000,
        40'b1000_0000_0100_0101_0100_0010_0100_0000_1000_0010,
        40'b0000_0000_0000_0011_0001_1101_0000_1100_1110_0010,
        40'b0000_0000_0001_1010_1010_0000_0101_0000_0001_0100,
        40'b0000_0101_0101_1010_1000_0101_0110_0000_0000_0000,
        40'b0000_0001_1100_0000_0110_0010_0000_0000_0100_1000
    };

    localparam score_t CLASS_BIAS [CLASS_CNT] = '{
        7'd3, 7'd3, 7'd3, 7'd3, 7'd0, 7'd7, 7'd0, 7'd7, 7'd0, 7'd6
    };

endpackage
